/* files.f */
verilog/glbl_pkg.sv
verilog/glbl_bus_fsm.sv
verilog/glbl_reg_file.sv
verilog/glbl_intr_stat.sv
verilog/glbl_clk_div.sv
verilog/glbl_reg_top.sv
tests/glbl_reg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
   -f files.f \
   --top-module glbl_reg_tb \
   --Mdir "$OBJ" \
   -o glbl_reg_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/glbl_reg_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tests/glbl_reg_tb.sv */
module glbl_reg_tb;

   import glbl_pkg::*;

   localparam logic [31:0] SIGNATURE_VAL = 32'h5A3C_9E71;
   localparam logic [31:0] RELEASE_VAL   = 32'h1357_2468;
   localparam logic [31:0] REVISION_VAL  = 32'h0006_3100;
   localparam int          ACK_LIMIT     = 10;
   localparam int          RTC_LIMIT     = 200;

   // One bus access with its expected read data
   typedef struct packed {
      logic        wr;
      logic [4:0]  addr;
      logic [31:0] data;
      logic [3:0]  be;
      logic [31:0] exp;
   } row_t;

   logic        mclk;
   logic        s_reset_n;
   logic        reg_cs;
   logic        reg_wr;
   bus_req_t    reg_req;
   logic [31:0] system_strap;
   intr_src_t   intr_src;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   rst_ctrl_t   rst_ctrl;
   logic [31:0] irq_lines;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [15:0] cfg_riscv_ctrl;
   logic [31:0] cfg_multi_func_sel;
   logic        rtc_clk;

   row_t        rows[$];
   logic [31:0] shadow [0:31];
   logic [15:0] lfsr;

   glbl_reg_top #(
      .CHIP_SIGNATURE    (SIGNATURE_VAL),
      .CHIP_RELEASE_DATE (RELEASE_VAL),
      .CHIP_REVISION     (REVISION_VAL),
      .CHIP_NUM          (4'h5),
      .RATIO_W           (5)
   ) dut (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .reg_cs             (reg_cs),
      .reg_wr             (reg_wr),
      .reg_req            (reg_req),
      .system_strap       (system_strap),
      .intr_src           (intr_src),
      .reg_rdata          (reg_rdata),
      .reg_ack            (reg_ack),
      .rst_ctrl           (rst_ctrl),
      .irq_lines          (irq_lines),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .rtc_clk            (rtc_clk)
   );

   initial begin
      mclk = 1'b0;
      forever #4 mclk = ~mclk;
   end

   // --------------------
   // Helpers
   // --------------------
   task automatic compare_word(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
      if (act !== exp) begin
         $display("CHECK FAILED at time %0t: %s = 0x%08h, expected 0x%08h",
                  $time, name, act, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at time %0t: %s", $time, what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // 16-bit Galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int count, output logic [31:0] w);
      w = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = lfsr_next(lfsr);
         w = {w[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [31:0] lane_merge(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0] be);
      logic [31:0] m;
      m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      return (old & ~m) | (data & m);
   endfunction

   // Reset outputs as CFG0 maps them
   function automatic rst_ctrl_t cfg0_to_rst(input logic [31:0] c);
      rst_ctrl_t r;
      r.cpu_intf_rst_n = c[0];
      r.qspim_rst_n    = c[1];
      r.sspim_rst_n    = c[2];
      r.uart_rst_n     = {c[6], c[3]};
      r.i2cm_rst_n     = c[4];
      r.usb_rst_n      = c[5];
      r.cpu_core_rst_n = c[9:8];
      return r;
   endfunction

   // Table building with a shadow of the map
   task automatic add_write(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
      rows.push_back('{wr: 1'b1, addr: addr, data: data, be: be, exp: 32'h0});
      case (addr)
         ADDR_CFG0, ADDR_CFG1, ADDR_MULTI_FUNC, ADDR_CLK_CTRL, ADDR_MAILBOX,
         ADDR_SW_SIGNATURE, ADDR_SW_RELEASE, ADDR_SW_REVISION, ADDR_SW_SCRATCH:
            shadow[addr] = lane_merge(shadow[addr], data, be);
         default: ;
      endcase
   endtask

   task automatic add_read(input logic [4:0] addr);
      rows.push_back('{wr: 1'b0, addr: addr, data: 32'h0, be: 4'h0, exp: shadow[addr]});
   endtask

   // Called on a falling edge, returns on one
   task automatic bus_access(input logic wr, input logic [4:0] addr,
                             input logic [31:0] data, input logic [3:0] be,
                             output logic [31:0] rdata);
      int waited;
      compare_word("reg_ack before access", {31'b0, reg_ack}, 32'd0);
      reg_cs        = 1'b1;
      reg_wr        = wr;
      reg_req.addr  = addr;
      reg_req.wdata = data;
      reg_req.be    = be;
      waited = 0;
      do begin
         @(negedge mclk);
         waited++;
      end while (!reg_ack && waited < ACK_LIMIT);
      if (!reg_ack) begin
         report_timeout("no reg_ack for a bus access");
      end
      rdata  = reg_rdata;
      reg_cs = 1'b0;
      reg_wr = 1'b0;
      // Ack lasts one cycle only
      @(negedge mclk);
      compare_word("reg_ack after one cycle", {31'b0, reg_ack}, 32'd0);
   endtask

   task automatic wait_rtc_level(input logic level);
      int waited;
      waited = 0;
      while (rtc_clk !== level && waited < RTC_LIMIT) begin
         @(negedge mclk);
         waited++;
      end
      if (rtc_clk !== level) begin
         report_timeout("rtc_clk never reached the awaited level");
      end
   endtask

   task automatic measure_rtc_phase(input logic level, output int n);
      n = 0;
      while (rtc_clk === level && n < RTC_LIMIT) begin
         n++;
         @(negedge mclk);
      end
      if (n >= RTC_LIMIT) begin
         report_timeout("rtc_clk phase never ended");
      end
   endtask

   // Enable at ratio r, time both phases, then disable
   task automatic measure_divider(input logic [4:0] r);
      logic [31:0] rd;
      int          n;
      bus_access(1'b1, ADDR_CLK_CTRL, {26'b0, 1'b1, r}, 4'h1, rd);
      wait_rtc_level(1'b0);
      wait_rtc_level(1'b1);
      measure_rtc_phase(1'b1, n);
      compare_word("rtc_clk high cycles", n, 32'(r) + 32'd1);
      measure_rtc_phase(1'b0, n);
      compare_word("rtc_clk low cycles", n, 32'(r) + 32'd1);
      bus_access(1'b1, ADDR_CLK_CTRL, {26'b0, 1'b0, r}, 4'h1, rd);
      for (int i = 0; i < 70; i++) begin
         compare_word("rtc_clk while disabled", {31'b0, rtc_clk}, 32'd0);
         @(negedge mclk);
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      chip_id_t    id_exp;
      logic [31:0] d;
      logic [31:0] be;
      logic [31:0] rd;
      logic [31:0] mask;
      logic [31:0] stat_exp;
      lfsr         = 16'd82;
      s_reset_n    = 1'b0;
      reg_cs       = 1'b0;
      reg_wr       = 1'b0;
      reg_req      = '0;
      intr_src     = '0;
      system_strap = 32'h0000_1000;

      // Shadow map at reset
      id_exp.f.manu_id    = 16'h8268;
      id_exp.f.total_core = 4'h1;
      id_exp.f.chip_num   = 4'h5;
      id_exp.f.chip_rev   = 8'h01;
      for (int i = 0; i < 32; i++) begin
         shadow[i] = 32'h0;
      end
      shadow[ADDR_CHIP_ID]      = id_exp.word;
      shadow[ADDR_CFG0]         = 32'h0000_0103;
      shadow[ADDR_MULTI_FUNC]   = 32'h8000_0000;
      shadow[ADDR_SW_SIGNATURE] = SIGNATURE_VAL;
      shadow[ADDR_SW_RELEASE]   = RELEASE_VAL;
      shadow[ADDR_SW_REVISION]  = REVISION_VAL;

      repeat (5) @(negedge mclk);
      s_reset_n = 1'b1;
      @(negedge mclk);

      compare_word("reg_ack", {31'b0, reg_ack}, 32'd0);
      compare_word("reg_rdata", reg_rdata, 32'd0);
      compare_word("rst_ctrl", {23'b0, rst_ctrl}, {23'b0, cfg0_to_rst(32'h103)});
      compare_word("irq_lines", irq_lines, 32'd0);
      compare_word("soft_irq", {31'b0, soft_irq}, 32'd0);
      compare_word("user_irq", {29'b0, user_irq}, 32'd0);
      compare_word("rtc_clk", {31'b0, rtc_clk}, 32'd0);
      compare_word("cfg_multi_func_sel", cfg_multi_func_sel, 32'h8000_0000);

      // Reset values of the map
      add_read(ADDR_CHIP_ID);
      add_read(ADDR_CFG0);
      add_read(ADDR_MULTI_FUNC);
      add_read(ADDR_SW_SIGNATURE);
      add_read(ADDR_SW_RELEASE);
      add_read(ADDR_SW_REVISION);
      add_read(ADDR_SW_SCRATCH);
      // Full word, then random lanes, then readback
      for (int k = 0; k < 4; k++) begin
         logic [4:0] a;
         a = (k == 0) ? ADDR_MAILBOX : (k == 1) ? ADDR_SW_SCRATCH :
             (k == 2) ? ADDR_CFG1 : ADDR_MULTI_FUNC;
         rand_bits(32, d);
         add_write(a, d, 4'hF);
         rand_bits(32, d);
         rand_bits(4, be);
         add_write(a, d, be[3:0]);
         add_read(a);
      end
      // Read-only id and holes
      for (int k = 0; k < 3; k++) begin
         logic [4:0] a;
         a = (k == 0) ? ADDR_CHIP_ID : (k == 1) ? 5'd9 : 5'd25;
         rand_bits(32, d);
         add_write(a, d, 4'hF);
         add_read(a);
      end
      rand_bits(32, d);
      add_write(ADDR_CFG0, d, 4'h3);
      add_read(ADDR_CFG0);
      rand_bits(32, d);
      add_write(ADDR_CFG1, d, 4'hF);
      add_read(ADDR_CFG1);

      foreach (rows[i]) begin
         bus_access(rows[i].wr, rows[i].addr, rows[i].data, rows[i].be, rd);
         if (!rows[i].wr) begin
            compare_word($sformatf("reg_rdata at address %0d", rows[i].addr),
                         rd, rows[i].exp);
         end
      end

      // CFG0 and CFG1 field mapping
      compare_word("rst_ctrl", {23'b0, rst_ctrl}, {23'b0, cfg0_to_rst(shadow[ADDR_CFG0])});
      compare_word("cfg_riscv_ctrl", {16'b0, cfg_riscv_ctrl}, {16'b0, shadow[ADDR_CFG1][31:16]});
      compare_word("soft_irq", {31'b0, soft_irq}, {31'b0, shadow[ADDR_CFG1][3]});
      compare_word("user_irq", {29'b0, user_irq}, {29'b0, shadow[ADDR_CFG1][2:0]});
      compare_word("cfg_multi_func_sel", cfg_multi_func_sel, shadow[ADDR_MULTI_FUNC]);

      // --------------------
      // Interrupts
      // --------------------
      rand_bits(32, mask);
      bus_access(1'b1, ADDR_INTR_MASK, mask, 4'hF, rd);
      bus_access(1'b0, ADDR_INTR_MASK, 32'h0, 4'h0, rd);
      compare_word("intr mask readback", rd, mask);
      // Low GPIO lines are not routed
      intr_src.gpio_intr = 32'h0000_00FF;
      @(negedge mclk);
      intr_src = '0;
      bus_access(1'b0, ADDR_INTR_STAT, 32'h0, 4'h0, rd);
      compare_word("intr status after gpio 7:0", rd, 32'h0);
      // One-cycle pulse on several sources
      rand_bits(32, d);
      intr_src.gpio_intr  = d;
      intr_src.pwm_intr   = 1'b1;
      intr_src.timer_intr = 3'b101;
      @(negedge mclk);
      intr_src = '0;
      stat_exp = (d & 32'hFFFF_FF00) | 32'h0000_0020 | 32'h0000_0005;
      bus_access(1'b0, ADDR_INTR_STAT, 32'h0, 4'h0, rd);
      compare_word("intr status after pulse", rd, stat_exp);
      compare_word("irq_lines", irq_lines, mask & stat_exp);
      // USB held high through the clears
      intr_src.usb_intr = 1'b1;
      bus_access(1'b1, ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'h1, rd);
      stat_exp = (stat_exp & 32'hFFFF_FF00) | 32'h0000_0010;
      bus_access(1'b0, ADDR_INTR_STAT, 32'h0, 4'h0, rd);
      compare_word("intr status after lane 0 clear", rd, stat_exp);
      compare_word("irq_lines", irq_lines, mask & stat_exp);
      bus_access(1'b1, ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'hF, rd);
      bus_access(1'b0, ADDR_INTR_STAT, 32'h0, 4'h0, rd);
      compare_word("intr status with usb held", rd, 32'h0000_0010);
      compare_word("irq_lines", irq_lines, mask & 32'h0000_0010);
      intr_src.usb_intr = 1'b0;
      bus_access(1'b1, ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'hF, rd);
      bus_access(1'b0, ADDR_INTR_STAT, 32'h0, 4'h0, rd);
      compare_word("intr status after final clear", rd, 32'h0);
      compare_word("irq_lines", irq_lines, 32'h0);

      // Divider at a fixed and a random ratio
      measure_divider(5'd3);
      rand_bits(5, d);
      measure_divider(d[4:0]);

      // --------------------
      // Ack pattern, cs held
      // --------------------
      reg_cs       = 1'b1;
      reg_wr       = 1'b0;
      reg_req.addr = ADDR_MAILBOX;
      for (int i = 0; i < 6; i++) begin
         @(negedge mclk);
         compare_word("reg_ack with cs held", {31'b0, reg_ack}, (i % 2 == 0) ? 32'd1 : 32'd0);
         if (reg_ack) begin
            compare_word("reg_rdata with cs held", reg_rdata, shadow[ADDR_MAILBOX]);
         end
         if (i == 4) begin
            reg_cs = 1'b0;
         end
      end
      @(negedge mclk);
      compare_word("reg_ack after cs drop", {31'b0, reg_ack}, 32'd0);

      $display("Testbench passed");
      $finish;
   end

endmodule

/* verilog/glbl_bus_fsm.sv */
module glbl_bus_fsm (
   input  logic mclk,
   input  logic s_reset_n,
   input  logic reg_cs,
   input  logic reg_wr,
   output logic acc_wr_stb,
   output logic acc_rd_stb,
   output logic reg_ack
);

   // Two states, ack lasts exactly one cycle
   localparam logic IDLE = 1'b0;
   localparam logic ACK  = 1'b1;

   logic state;
   logic next_state;
   logic start;

   // Access starts on the edge that sees cs in idle
   assign start = (state == IDLE) && reg_cs;

   // --------------------
   // Next state
   // --------------------
   always_comb begin
      case (state)
         IDLE: begin
            next_state = reg_cs ? ACK : IDLE;
         end
         default: begin
            // Always back to idle after ack
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Strobes act at the start edge itself
   assign acc_wr_stb = start & reg_wr;
   assign acc_rd_stb = start & ~reg_wr;

   // Ack straight from the state flop
   assign reg_ack = (state == ACK);

endmodule

/* verilog/glbl_clk_div.sv */
module glbl_clk_div #(
   parameter int RATIO_W = 5
) (
   input  logic               mclk,
   input  logic               s_reset_n,
   input  logic               div_enb,
   input  logic [RATIO_W-1:0] div_ratio,
   output logic               rtc_clk
);

   logic [RATIO_W-1:0] cnt;
   logic               reload;

   // Terminal count, toggle and reload here
   assign reload = (cnt == '0);

   // --------------------
   // Down counter
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         cnt <= '0;
      end else if (!div_enb) begin
         // Held cleared while off
         cnt <= '0;
      end else if (reload) begin
         cnt <= div_ratio;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // Output phase, ratio+1 mclk cycles each
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rtc_clk <= 1'b0;
      end else if (!div_enb) begin
         rtc_clk <= 1'b0;
      end else if (reload) begin
         rtc_clk <= ~rtc_clk;
      end
   end

endmodule

/* verilog/glbl_intr_stat.sv */
module glbl_intr_stat (
   input  logic                        mclk,
   input  logic                        s_reset_n,
   input  logic [glbl_pkg::DATA_W-1:0] wdata,
   input  logic [glbl_pkg::BE_W-1:0]   mask_wr_be,
   input  logic [glbl_pkg::DATA_W-1:0] intr_clr,
   input  glbl_pkg::intr_src_t         intr_src,
   output logic [glbl_pkg::DATA_W-1:0] intr_mask,
   output logic [glbl_pkg::DATA_W-1:0] intr_stat,
   output logic [glbl_pkg::DATA_W-1:0] irq_lines
);

   import glbl_pkg::*;

   logic [DATA_W-1:0] hw_req;

   // --------------------
   // Request word
   // --------------------
   // GPIO 7:0 not routed here, bits 7:6 stay zero
   assign hw_req = {intr_src.gpio_intr[31:8],
                    2'b00,
                    intr_src.pwm_intr,
                    intr_src.usb_intr,
                    intr_src.i2cm_intr,
                    intr_src.timer_intr};

   // Mask register, byte writes
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask <= '0;
      end else if (|mask_wr_be) begin
         intr_mask <= byte_merge(intr_mask, wdata, mask_wr_be);
      end
   end

   // --------------------
   // Status register
   // --------------------
   // Request sets, clear lane drops, set has priority
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         intr_stat <= hw_req | (intr_stat & ~intr_clr);
      end
   end

   // Masked lines to the CPU
   assign irq_lines = intr_mask & intr_stat;

endmodule

/* verilog/glbl_pkg.sv */
package glbl_pkg;

   // --------------------
   // Bus and word widths
   // --------------------
   localparam int DATA_W = 32;
   localparam int ADDR_W = 5;
   localparam int BE_W   = 4;

   // --------------------
   // Register map
   // --------------------
   localparam logic [ADDR_W-1:0] ADDR_CHIP_ID      = 5'd0;
   localparam logic [ADDR_W-1:0] ADDR_CFG0         = 5'd1;
   localparam logic [ADDR_W-1:0] ADDR_CFG1         = 5'd2;
   localparam logic [ADDR_W-1:0] ADDR_INTR_MASK    = 5'd3;
   localparam logic [ADDR_W-1:0] ADDR_INTR_STAT    = 5'd4;
   localparam logic [ADDR_W-1:0] ADDR_MULTI_FUNC   = 5'd5;
   localparam logic [ADDR_W-1:0] ADDR_CLK_CTRL     = 5'd6;
   localparam logic [ADDR_W-1:0] ADDR_MAILBOX      = 5'd15;
   localparam logic [ADDR_W-1:0] ADDR_SW_SIGNATURE = 5'd16;
   localparam logic [ADDR_W-1:0] ADDR_SW_RELEASE   = 5'd17;
   localparam logic [ADDR_W-1:0] ADDR_SW_REVISION  = 5'd18;
   localparam logic [ADDR_W-1:0] ADDR_SW_SCRATCH   = 5'd19;

   // Boot strap bit, 1 releases CPU core 0 from reset
   localparam int STRAP_RISCV_RESET_MODE = 12;

   // Register bus request, sampled with reg_cs
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } bus_req_t;

   // Chip identification fields, top bit first
   typedef struct packed {
      logic [15:0] manu_id;
      logic [3:0]  total_core;
      logic [3:0]  chip_num;
      logic [7:0]  chip_rev;
   } chip_id_fields_t;

   // Same chip id word seen whole or by field
   typedef union packed {
      logic [DATA_W-1:0] word;
      chip_id_fields_t   f;
   } chip_id_t;

   // Active-low block resets
   typedef struct packed {
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic [1:0] uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
      logic [1:0] cpu_core_rst_n;
   } rst_ctrl_t;

   // Hardware interrupt requests
   typedef struct packed {
      logic [31:0] gpio_intr;
      logic        pwm_intr;
      logic        usb_intr;
      logic        i2cm_intr;
      logic [2:0]  timer_intr;
   } intr_src_t;

   // RTC divider setup from the clock control word
   typedef struct packed {
      logic       div_enb;
      logic [4:0] div_ratio;
   } rtc_clk_cfg_t;

   // Merge write data into a word, one byte per enable
   function automatic logic [DATA_W-1:0] byte_merge(
      input logic [DATA_W-1:0] cur,
      input logic [DATA_W-1:0] wdata,
      input logic [BE_W-1:0]   be
   );
      logic [DATA_W-1:0] res;
      res = cur;
      for (int i = 0; i < BE_W; i++) begin
         if (be[i]) begin
            res[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      return res;
   endfunction

endpackage

/* verilog/glbl_reg_file.sv */
module glbl_reg_file #(
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_SIGNATURE    = 32'h8273_8343,
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_RELEASE_DATE = 32'h0000_0000,
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_REVISION     = 32'h0005_2000,
   parameter logic [3:0]                  CHIP_NUM          = 4'h5
) (
   input  logic                          mclk,
   input  logic                          s_reset_n,
   input  glbl_pkg::bus_req_t            req,
   input  logic                          acc_wr_stb,
   input  logic                          acc_rd_stb,
   input  logic [glbl_pkg::DATA_W-1:0]   system_strap,
   input  logic [glbl_pkg::DATA_W-1:0]   intr_mask,
   input  logic [glbl_pkg::DATA_W-1:0]   intr_stat,
   output logic [glbl_pkg::DATA_W-1:0]   reg_rdata,
   output glbl_pkg::rst_ctrl_t           rst_ctrl,
   output logic [15:0]                   cfg_riscv_ctrl,
   output logic                          soft_irq,
   output logic [2:0]                    user_irq,
   output logic [glbl_pkg::DATA_W-1:0]   cfg_multi_func_sel,
   output logic [glbl_pkg::BE_W-1:0]     mask_wr_be,
   output logic [glbl_pkg::DATA_W-1:0]   intr_clr,
   output glbl_pkg::rtc_clk_cfg_t        rtc_cfg
);

   import glbl_pkg::*;

   chip_id_t          chip_id;
   logic [DATA_W-1:0] cfg0_rst;
   logic [DATA_W-1:0] cfg0;
   logic [DATA_W-1:0] cfg1;
   logic [DATA_W-1:0] multi_func;
   logic [DATA_W-1:0] clk_ctrl;
   logic [DATA_W-1:0] mailbox;
   logic [DATA_W-1:0] sw_signature;
   logic [DATA_W-1:0] sw_release;
   logic [DATA_W-1:0] sw_revision;
   logic [DATA_W-1:0] sw_scratch;
   logic [DATA_W-1:0] rd_mux;
   logic              stat_wr;

   // Fixed id word, read only
   assign chip_id.f = '{manu_id: 16'h8268, total_core: 4'h1,
                        chip_num: CHIP_NUM, chip_rev: 8'h01};

   // Core 0 comes out of reset only with the boot strap set
   assign cfg0_rst = system_strap[STRAP_RISCV_RESET_MODE] ? 32'h0000_0103 : 32'h0000_0003;

   // --------------------
   // Writable registers
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         cfg0         <= cfg0_rst;
         cfg1         <= '0;
         multi_func   <= 32'h8000_0000;
         clk_ctrl     <= '0;
         mailbox      <= '0;
         sw_signature <= CHIP_SIGNATURE;
         sw_release   <= CHIP_RELEASE_DATE;
         sw_revision  <= CHIP_REVISION;
         sw_scratch   <= '0;
      end else if (acc_wr_stb) begin
         case (req.addr)
            ADDR_CFG0:         cfg0         <= byte_merge(cfg0, req.wdata, req.be);
            ADDR_CFG1:         cfg1         <= byte_merge(cfg1, req.wdata, req.be);
            ADDR_MULTI_FUNC:   multi_func   <= byte_merge(multi_func, req.wdata, req.be);
            ADDR_CLK_CTRL:     clk_ctrl     <= byte_merge(clk_ctrl, req.wdata, req.be);
            ADDR_MAILBOX:      mailbox      <= byte_merge(mailbox, req.wdata, req.be);
            ADDR_SW_SIGNATURE: sw_signature <= byte_merge(sw_signature, req.wdata, req.be);
            ADDR_SW_RELEASE:   sw_release   <= byte_merge(sw_release, req.wdata, req.be);
            ADDR_SW_REVISION:  sw_revision  <= byte_merge(sw_revision, req.wdata, req.be);
            ADDR_SW_SCRATCH:   sw_scratch   <= byte_merge(sw_scratch, req.wdata, req.be);
            // Chip id, mask, status and holes
            default: ;
         endcase
      end
   end

   // Reset controls, uart and core bits are split
   assign rst_ctrl.cpu_intf_rst_n = cfg0[0];
   assign rst_ctrl.qspim_rst_n    = cfg0[1];
   assign rst_ctrl.sspim_rst_n    = cfg0[2];
   assign rst_ctrl.uart_rst_n     = {cfg0[6], cfg0[3]};
   assign rst_ctrl.i2cm_rst_n     = cfg0[4];
   assign rst_ctrl.usb_rst_n      = cfg0[5];
   assign rst_ctrl.cpu_core_rst_n = cfg0[9:8];

   // CFG1 interrupt and core control fields
   assign cfg_riscv_ctrl = cfg1[31:16];
   assign soft_irq       = cfg1[3];
   assign user_irq       = cfg1[2:0];

   assign cfg_multi_func_sel = multi_func;

   // RTC divider enable and ratio
   assign rtc_cfg.div_enb   = clk_ctrl[5];
   assign rtc_cfg.div_ratio = clk_ctrl[4:0];

   // --------------------
   // Interrupt block hooks
   // --------------------
   assign mask_wr_be = (acc_wr_stb && req.addr == ADDR_INTR_MASK) ? req.be : '0;
   assign stat_wr    = acc_wr_stb && (req.addr == ADDR_INTR_STAT);

   // Write one to clear, byte lanes widened
   always_comb begin
      for (int i = 0; i < BE_W; i++) begin
         intr_clr[8*i +: 8] = {8{stat_wr & req.be[i]}} & req.wdata[8*i +: 8];
      end
   end

   // --------------------
   // Read path
   // --------------------
   always_comb begin
      case (req.addr)
         ADDR_CHIP_ID:      rd_mux = chip_id.word;
         ADDR_CFG0:         rd_mux = cfg0;
         ADDR_CFG1:         rd_mux = cfg1;
         ADDR_INTR_MASK:    rd_mux = intr_mask;
         ADDR_INTR_STAT:    rd_mux = intr_stat;
         ADDR_MULTI_FUNC:   rd_mux = multi_func;
         ADDR_CLK_CTRL:     rd_mux = clk_ctrl;
         ADDR_MAILBOX:      rd_mux = mailbox;
         ADDR_SW_SIGNATURE: rd_mux = sw_signature;
         ADDR_SW_RELEASE:   rd_mux = sw_release;
         ADDR_SW_REVISION:  rd_mux = sw_revision;
         ADDR_SW_SCRATCH:   rd_mux = sw_scratch;
         default:           rd_mux = '0;
      endcase
   end

   // Loaded on any access, only reads carry meaning
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_rdata <= '0;
      end else if (acc_wr_stb || acc_rd_stb) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

/* verilog/glbl_reg_top.sv */
module glbl_reg_top #(
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_SIGNATURE    = 32'h8273_8343,
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_RELEASE_DATE = 32'h0000_0000,
   parameter logic [glbl_pkg::DATA_W-1:0] CHIP_REVISION     = 32'h0005_2000,
   parameter logic [3:0]                  CHIP_NUM          = 4'h5,
   parameter int                          RATIO_W           = 5
) (
   input  logic                        mclk,
   input  logic                        s_reset_n,
   input  logic                        reg_cs,
   input  logic                        reg_wr,
   input  glbl_pkg::bus_req_t          reg_req,
   input  logic [glbl_pkg::DATA_W-1:0] system_strap,
   input  glbl_pkg::intr_src_t         intr_src,
   output logic [glbl_pkg::DATA_W-1:0] reg_rdata,
   output logic                        reg_ack,
   output glbl_pkg::rst_ctrl_t         rst_ctrl,
   output logic [glbl_pkg::DATA_W-1:0] irq_lines,
   output logic                        soft_irq,
   output logic [2:0]                  user_irq,
   output logic [15:0]                 cfg_riscv_ctrl,
   output logic [glbl_pkg::DATA_W-1:0] cfg_multi_func_sel,
   output logic                        rtc_clk
);

   import glbl_pkg::*;

   logic              acc_wr_stb;
   logic              acc_rd_stb;
   logic [DATA_W-1:0] intr_mask;
   logic [DATA_W-1:0] intr_stat;
   logic [BE_W-1:0]   mask_wr_be;
   logic [DATA_W-1:0] intr_clr;
   rtc_clk_cfg_t      rtc_cfg;

   // --------------------
   // Bus sequencing
   // --------------------
   glbl_bus_fsm u_bus_fsm (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_cs     (reg_cs),
      .reg_wr     (reg_wr),
      .acc_wr_stb (acc_wr_stb),
      .acc_rd_stb (acc_rd_stb),
      .reg_ack    (reg_ack)
   );

   // Register map and read data
   glbl_reg_file #(
      .CHIP_SIGNATURE    (CHIP_SIGNATURE),
      .CHIP_RELEASE_DATE (CHIP_RELEASE_DATE),
      .CHIP_REVISION     (CHIP_REVISION),
      .CHIP_NUM          (CHIP_NUM)
   ) u_reg_file (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .req                (reg_req),
      .acc_wr_stb         (acc_wr_stb),
      .acc_rd_stb         (acc_rd_stb),
      .system_strap       (system_strap),
      .intr_mask          (intr_mask),
      .intr_stat          (intr_stat),
      .reg_rdata          (reg_rdata),
      .rst_ctrl           (rst_ctrl),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .mask_wr_be         (mask_wr_be),
      .intr_clr           (intr_clr),
      .rtc_cfg            (rtc_cfg)
   );

   // Interrupt mask and status
   glbl_intr_stat u_intr_stat (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .wdata      (reg_req.wdata),
      .mask_wr_be (mask_wr_be),
      .intr_clr   (intr_clr),
      .intr_src   (intr_src),
      .intr_mask  (intr_mask),
      .intr_stat  (intr_stat),
      .irq_lines  (irq_lines)
   );

   // RTC clock from mclk
   glbl_clk_div #(
      .RATIO_W (RATIO_W)
   ) u_rtc_div (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .div_enb   (rtc_cfg.div_enb),
      .div_ratio (rtc_cfg.div_ratio),
      .rtc_clk   (rtc_clk)
   );

endmodule
